// File: common/figurePkg.sv
package figurePkg;

  localparam int xWidth = 10;
  localparam int yWidth = 9;

  typedef logic [xWidth-1:0] pixelX;
  typedef logic [yWidth-1:0] pixelY;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
  } rgbColour;

  localparam int numParts = 5;

  // layer order, higher index is drawn in front
  localparam int partPants = 0;
  localparam int partBody  = 1;
  localparam int partArmL  = 2;
  localparam int partArmR  = 3;
  localparam int partHead  = 4;

  // geometry relative to the figure anchor, indexed by layer
  localparam int partOffsetX [numParts] = '{0, 0, -20, 95, 0};
  localparam int partOffsetY [numParts] = '{160, 90, 80, 75, 0};
  localparam int partWidth   [numParts] = '{100, 100, 20, 25, 100};
  localparam int partHeight  [numParts] = '{40, 70, 60, 60, 90};
  localparam int partCut     [numParts] = '{4, 0, 3, 3, 12};

  localparam rgbColour partColour [numParts] = '{
    24'h2c3e9a,  // pants
    24'hf0f0e8,  // body
    24'hd09868,  // left arm
    24'hc88c5c,  // right arm
    24'hf2c8a0   // head
  };

endpackage

// File: spriteBlock/spriteShape.sv
module spriteShape #(
  parameter int width = 16,
  parameter int height = 16,
  parameter int cornerCut = 0,
  parameter figurePkg::rgbColour baseColour = '0
) (
  input  figurePkg::pixelX    relX,
  input  figurePkg::pixelY    relY,
  output logic                inMask,
  output figurePkg::rgbColour shade
);

  // cut square limits, right and bottom squares start at size - cut
  localparam figurePkg::pixelX cutLeft   = figurePkg::pixelX'(cornerCut);
  localparam figurePkg::pixelX cutRight  = figurePkg::pixelX'(width - cornerCut);
  localparam figurePkg::pixelY cutTop    = figurePkg::pixelY'(cornerCut);
  localparam figurePkg::pixelY cutBottom = figurePkg::pixelY'(height - cornerCut);

  localparam figurePkg::pixelX lastCol = figurePkg::pixelX'(width - 1);
  localparam figurePkg::pixelY lastRow = figurePkg::pixelY'(height - 1);

  localparam figurePkg::rgbColour halfColour = '{
    red:   baseColour.red >> 1,
    green: baseColour.green >> 1,
    blue:  baseColour.blue >> 1
  };

  logic inLeft;
  logic inRight;
  logic inTop;
  logic inBottom;
  logic onBorder;

  // with cornerCut 0 the right/bottom tests only pass outside the box
  assign inLeft   = relX < cutLeft;
  assign inRight  = relX >= cutRight;
  assign inTop    = relY < cutTop;
  assign inBottom = relY >= cutBottom;

  assign inMask = !((inLeft || inRight) && (inTop || inBottom));

  assign onBorder = (relX == '0) || (relX == lastCol) ||
                    (relY == '0) || (relY == lastRow);

  assign shade = onBorder ? halfColour : baseColour;  // outline at half intensity

endmodule

// File: spriteBlock/spriteBlock.sv
module spriteBlock #(
  parameter int offsetX = 0,
  parameter int offsetY = 0,
  parameter int width = 16,
  parameter int height = 16,
  parameter int cornerCut = 0,
  parameter figurePkg::rgbColour baseColour = '0
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic                enable,
  input  logic                motionEn,
  input  figurePkg::pixelX    pixX,
  input  figurePkg::pixelY    pixY,
  input  figurePkg::pixelX    curX,
  input  figurePkg::pixelY    curY,
  input  figurePkg::pixelX    initX,
  input  figurePkg::pixelY    initY,
  output logic                hit,
  output figurePkg::rgbColour colour
);

  figurePkg::pixelX    anchorX;
  figurePkg::pixelY    anchorY;
  figurePkg::pixelX    cornerX;
  figurePkg::pixelY    cornerY;
  figurePkg::pixelX    relX;
  figurePkg::pixelY    relY;
  logic                inBox;
  logic                inMask;
  logic                hitNext;
  figurePkg::rgbColour shade;

  // moving figure follows cur, otherwise parked at init
  assign anchorX = motionEn ? curX : initX;
  assign anchorY = motionEn ? curY : initY;

  // negative offsets wrap modulo the coordinate width
  assign cornerX = anchorX + figurePkg::pixelX'(offsetX);
  assign cornerY = anchorY + figurePkg::pixelY'(offsetY);

  assign relX = pixX - cornerX;  // points left of the corner wrap high and fail the box
  assign relY = pixY - cornerY;

  assign inBox = (relX < figurePkg::pixelX'(width)) &&
                 (relY < figurePkg::pixelY'(height));

  spriteShape #(
    .width(width),
    .height(height),
    .cornerCut(cornerCut),
    .baseColour(baseColour)
  ) shape (
    .relX(relX),
    .relY(relY),
    .inMask(inMask),
    .shade(shade)
  );

  assign hitNext = enable && inBox && inMask;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      hit <= 1'b0;
    end else begin
      hit <= hitNext;
    end
  end

  always_ff @(posedge clk) begin
    colour <= hitNext ? shade : '0;
  end

endmodule

// File: design/figureCompositor.sv
module figureCompositor #(
  parameter int numLayers = figurePkg::numParts
) (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic [numLayers-1:0] layerHit,
  input  figurePkg::rgbColour  layerColour [numLayers],
  output logic                 pixValid,
  output figurePkg::rgbColour  pixColour
);

  logic                pickValid;
  figurePkg::rgbColour pickColour;

  // later iterations overwrite, so the highest set layer is kept
  always_comb begin
    pickValid  = 1'b0;
    pickColour = '0;
    for (int i = 0; i < numLayers; i++) begin
      if (layerHit[i]) begin
        pickValid  = 1'b1;
        pickColour = layerColour[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pixValid  <= 1'b0;
      pixColour <= '0;
    end else begin
      pixValid  <= pickValid;
      pixColour <= pickColour;  // zero when nothing covers the pixel
    end
  end

endmodule

// File: design/drawFigure.sv
module drawFigure (
  input  logic                clk,
  input  logic                rstN,
  input  logic                enable,
  input  logic                motionEn,
  input  figurePkg::pixelX    pixX,
  input  figurePkg::pixelY    pixY,
  input  figurePkg::pixelX    curX,
  input  figurePkg::pixelY    curY,
  input  figurePkg::pixelX    initX,
  input  figurePkg::pixelY    initY,
  output logic                pixValid,
  output figurePkg::rgbColour pixColour
);

  logic [figurePkg::numParts-1:0] layerHit;
  figurePkg::rgbColour            layerColour [figurePkg::numParts];

  spriteBlock #(
    .offsetX(figurePkg::partOffsetX[figurePkg::partPants]),
    .offsetY(figurePkg::partOffsetY[figurePkg::partPants]),
    .width(figurePkg::partWidth[figurePkg::partPants]),
    .height(figurePkg::partHeight[figurePkg::partPants]),
    .cornerCut(figurePkg::partCut[figurePkg::partPants]),
    .baseColour(figurePkg::partColour[figurePkg::partPants])
  ) pantsPart (
    .*,
    .hit(layerHit[figurePkg::partPants]),
    .colour(layerColour[figurePkg::partPants])
  );

  spriteBlock #(
    .offsetX(figurePkg::partOffsetX[figurePkg::partBody]),
    .offsetY(figurePkg::partOffsetY[figurePkg::partBody]),
    .width(figurePkg::partWidth[figurePkg::partBody]),
    .height(figurePkg::partHeight[figurePkg::partBody]),
    .cornerCut(figurePkg::partCut[figurePkg::partBody]),
    .baseColour(figurePkg::partColour[figurePkg::partBody])
  ) bodyPart (
    .*,
    .hit(layerHit[figurePkg::partBody]),
    .colour(layerColour[figurePkg::partBody])
  );

  spriteBlock #(
    .offsetX(figurePkg::partOffsetX[figurePkg::partArmL]),
    .offsetY(figurePkg::partOffsetY[figurePkg::partArmL]),
    .width(figurePkg::partWidth[figurePkg::partArmL]),
    .height(figurePkg::partHeight[figurePkg::partArmL]),
    .cornerCut(figurePkg::partCut[figurePkg::partArmL]),
    .baseColour(figurePkg::partColour[figurePkg::partArmL])
  ) armLPart (
    .*,
    .hit(layerHit[figurePkg::partArmL]),
    .colour(layerColour[figurePkg::partArmL])
  );

  spriteBlock #(
    .offsetX(figurePkg::partOffsetX[figurePkg::partArmR]),
    .offsetY(figurePkg::partOffsetY[figurePkg::partArmR]),
    .width(figurePkg::partWidth[figurePkg::partArmR]),
    .height(figurePkg::partHeight[figurePkg::partArmR]),
    .cornerCut(figurePkg::partCut[figurePkg::partArmR]),
    .baseColour(figurePkg::partColour[figurePkg::partArmR])
  ) armRPart (
    .*,
    .hit(layerHit[figurePkg::partArmR]),
    .colour(layerColour[figurePkg::partArmR])
  );

  // head sits on the top layer
  spriteBlock #(
    .offsetX(figurePkg::partOffsetX[figurePkg::partHead]),
    .offsetY(figurePkg::partOffsetY[figurePkg::partHead]),
    .width(figurePkg::partWidth[figurePkg::partHead]),
    .height(figurePkg::partHeight[figurePkg::partHead]),
    .cornerCut(figurePkg::partCut[figurePkg::partHead]),
    .baseColour(figurePkg::partColour[figurePkg::partHead])
  ) headPart (
    .*,
    .hit(layerHit[figurePkg::partHead]),
    .colour(layerColour[figurePkg::partHead])
  );

  figureCompositor #(
    .numLayers(figurePkg::numParts)
  ) compositor (
    .clk(clk),
    .rstN(rstN),
    .layerHit(layerHit),
    .layerColour(layerColour),
    .pixValid(pixValid),
    .pixColour(pixColour)
  );

endmodule

// File: testbench/drawFigureTb_sva.sv
module drawFigureTb_sva #(
  parameter int numLayers = figurePkg::numParts
) (
  input logic                 clk,
  input logic                 rstN,
  input logic [numLayers-1:0] layerHit,
  input logic                 pixValid,
  input figurePkg::rgbColour  pixColour
);
  timeunit 1ns;
  timeprecision 100ps;

  resetClear: assert property (@(posedge clk) !rstN |-> !pixValid)
    else $error("pixValid high while reset is asserted");

  // colour is forced black whenever no layer covers the pixel
  blankColour: assert property (@(posedge clk) !pixValid |-> pixColour == '0)
    else $error("pixColour not zero while pixValid is low");

  emptyHitBlank: assert property (@(posedge clk) disable iff (!rstN)
    layerHit == '0 |=> !pixValid)
    else $error("pixValid set one cycle after an empty hit vector");

endmodule

bind figureCompositor drawFigureTb_sva #(
  .numLayers(numLayers)
) compositorChecks (
  .clk(clk),
  .rstN(rstN),
  .layerHit(layerHit),
  .pixValid(pixValid),
  .pixColour(pixColour)
);

// File: testbench/drawFigureTb.sv
module drawFigureTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int xMask = (1 << figurePkg::xWidth) - 1;
  localparam int yMask = (1 << figurePkg::yWidth) - 1;

  logic                clk;
  logic                rstN;
  logic                enable;
  logic                motionEn;
  figurePkg::pixelX    pixX;
  figurePkg::pixelY    pixY;
  figurePkg::pixelX    curX;
  figurePkg::pixelY    curY;
  figurePkg::pixelX    initX;
  figurePkg::pixelY    initY;
  logic                pixValid;
  figurePkg::rgbColour pixColour;

  // entry 1 holds the older of the two coordinates in flight
  logic                pipeValid [2];
  figurePkg::rgbColour pipeColour [2];
  int                  pipeX [2];
  int                  pipeY [2];

  int          validErrors;
  int          colourErrors;
  int          otherErrors;
  logic [31:0] lfsr;

  drawFigure UUT (.*);

  always #4 clk = ~clk;

  function automatic logic nextBit();
    logic lsb;
    lsb = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb) begin
      lfsr = lfsr ^ 32'h8020_0003;  // taps 32, 22, 2, 1
    end
    return lsb;
  endfunction

  function automatic int randBits(input int n);
    int value;
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(nextBit());
    end
    return value;
  endfunction

  // the frontmost covering part gives the colour
  function automatic void modelPixel(input int x, input int y, output logic valid,
                                     output figurePkg::rgbColour colour);
    int ax;
    int ay;
    int rx;
    int ry;
    int w;
    int h;
    int cut;
    logic cutCorner;
    figurePkg::rgbColour base;
    valid = 1'b0;
    colour = '0;
    ax = motionEn ? int'(curX) : int'(initX);
    ay = motionEn ? int'(curY) : int'(initY);
    for (int p = figurePkg::numParts - 1; p >= 0; p--) begin
      w = figurePkg::partWidth[p];
      h = figurePkg::partHeight[p];
      cut = figurePkg::partCut[p];
      base = figurePkg::partColour[p];
      rx = (x - ax - figurePkg::partOffsetX[p]) & xMask;
      ry = (y - ay - figurePkg::partOffsetY[p]) & yMask;
      cutCorner = (rx < cut || rx >= w - cut) && (ry < cut || ry >= h - cut);
      if (!valid && enable && rx < w && ry < h && !cutCorner) begin
        valid = 1'b1;
        colour = base;
        if (rx == 0 || ry == 0 || rx == w - 1 || ry == h - 1) begin
          colour.red = base.red >> 1;  // outline drawn at half intensity
          colour.green = base.green >> 1;
          colour.blue = base.blue >> 1;
        end
      end
    end
  endfunction

  task automatic compareValid(input logic got, input logic expected, input string what);
    if (got !== expected) begin
      validErrors++;
      $display("Error at %0t ns: pixValid %b for %s, expected %b", $time, got, what, expected);
    end
  endtask

  task automatic compareColour(input figurePkg::rgbColour got,
                               input figurePkg::rgbColour expected, input string what);
    if (got !== expected) begin
      colourErrors++;
      $display("Error at %0t ns: pixColour %h for %s, expected %h", $time, got, what, expected);
    end
  endtask

  task automatic clearPipe();
    for (int i = 0; i < 2; i++) begin
      pipeValid[i] = 1'b0;
      pipeColour[i] = '0;
      pipeX[i] = 0;
      pipeY[i] = 0;
    end
  endtask

  // drives one coordinate, then checks the output for the coordinate before it
  task automatic sendPixel(input int x, input int y);
    string what;
    pipeValid[1] = pipeValid[0];
    pipeColour[1] = pipeColour[0];
    pipeX[1] = pipeX[0];
    pipeY[1] = pipeY[0];
    pipeX[0] = x & xMask;
    pipeY[0] = y & yMask;
    pixX = figurePkg::pixelX'(pipeX[0]);
    pixY = figurePkg::pixelY'(pipeY[0]);
    modelPixel(pipeX[0], pipeY[0], pipeValid[0], pipeColour[0]);
    @(posedge clk);
    #1;
    what = $sformatf("pixel (%0d,%0d)", pipeX[1], pipeY[1]);
    compareValid(pixValid, pipeValid[1], what);
    compareColour(pixColour, pipeColour[1], what);
  endtask

  task automatic flushPipe();
    sendPixel(0, 0);
    sendPixel(0, 0);
  endtask

  task automatic placeFigure(input int ix, input int iy, input int cx, input int cy);
    initX = figurePkg::pixelX'(ix);
    initY = figurePkg::pixelY'(iy);
    curX = figurePkg::pixelX'(cx);
    curY = figurePkg::pixelY'(cy);
  endtask

  task automatic waitOutputsClear(output logic cleared);
    int cycles;
    cycles = 0;
    while ((pixValid !== 1'b0 || pixColour !== '0) && cycles < 10) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    cleared = pixValid === 1'b0 && pixColour === '0;
    if (!cleared) begin
      otherErrors++;
      $display("Outputs still not clear %0d cycles after reset was released", cycles);
    end
  endtask

  task automatic resetMidStream();
    compareValid(pixValid, 1'b0, "idle output after reset");
    compareColour(pixColour, '0, "idle output after reset");
    placeFigure(200, 100, 600, 300);
    enable = 1'b1;
    motionEn = 1'b0;
    for (int i = 0; i < 6; i++) begin
      sendPixel(240 + i, 130);
    end
    rstN = 1'b0;  // clears asynchronously between edges
    #1;
    compareValid(pixValid, 1'b0, "reset in mid-stream");
    compareColour(pixColour, '0, "reset in mid-stream");
    repeat (3) @(posedge clk);
    #1;
    compareValid(pixValid, 1'b0, "held in reset");
    rstN = 1'b1;
    clearPipe();
    for (int i = 0; i < 6; i++) begin
      sendPixel(240 + i, 130);
    end
    flushPipe();
  endtask

  task automatic scanPartEdges();
    int ox;
    int oy;
    int w;
    int h;
    int c;
    placeFigure(200, 100, 600, 300);
    enable = 1'b1;
    motionEn = 1'b0;
    for (int p = 0; p < figurePkg::numParts; p++) begin
      ox = 200 + figurePkg::partOffsetX[p];
      oy = 100 + figurePkg::partOffsetY[p];
      w = figurePkg::partWidth[p];
      h = figurePkg::partHeight[p];
      c = figurePkg::partCut[p];
      sendPixel(ox + w / 2, oy + h / 2);  // interior
      sendPixel(ox, oy + h / 2);
      sendPixel(ox + w - 1, oy + h / 2);
      sendPixel(ox + w / 2, oy);
      sendPixel(ox + w / 2, oy + h - 1);
      sendPixel(ox, oy);  // cut away unless the part has no cut
      sendPixel(ox + w - 1, oy + h - 1);
      sendPixel(ox + c, oy);
      sendPixel(ox + c - 1, oy + c - 1);
      sendPixel(ox + w, oy + h / 2);
    end
    flushPipe();
  endtask

  task automatic overlapPriority();
    placeFigure(200, 100, 600, 300);
    enable = 1'b1;
    motionEn = 1'b0;
    for (int i = 285; i < 310; i++) begin
      sendPixel(i, 176);  // head over the top of the right arm
    end
    for (int i = 170; i < 240; i++) begin
      sendPixel(297, i);  // right arm over body
    end
    flushPipe();
  endtask

  task automatic switchAnchor();
    placeFigure(200, 100, 500, 250);
    enable = 1'b1;
    motionEn = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (i == 4) begin
        motionEn = 1'b1;
      end
      sendPixel((i % 2) ? 550 : 250, (i % 2) ? 295 : 145);
    end
    flushPipe();
    motionEn = 1'b0;
  endtask

  task automatic toggleEnable();
    logic [15:0] pattern;
    pattern = 16'b1011_0011_1000_1101;
    placeFigure(200, 100, 600, 300);
    motionEn = 1'b0;
    enable = 1'b0;
    for (int i = 0; i < 6; i++) begin
      sendPixel(230 + i, 140);
    end
    for (int i = 0; i < 16; i++) begin
      enable = pattern[i];
      sendPixel(230 + i, 140);
    end
    flushPipe();
  endtask

  task automatic randomPixels();
    int ax;
    int ay;
    ax = 20 + randBits(10) % 800;
    ay = randBits(9) % 300;
    placeFigure(randBits(10), randBits(9), ax, ay);
    motionEn = 1'b1;
    for (int i = 0; i < 500; i++) begin
      enable = randBits(3) != 0;
      sendPixel(ax - 30 + randBits(8) % 170, ay - 10 + randBits(8) % 220);
    end
    flushPipe();
  endtask

  initial begin
    logic cleared;
    clk = 1'b0;
    rstN = 1'b0;
    enable = 1'b0;
    motionEn = 1'b0;
    pixX = '0;
    pixY = '0;
    placeFigure(0, 0, 0, 0);
    validErrors = 0;
    colourErrors = 0;
    otherErrors = 0;
    lfsr = 32'hdbb3_f241;
    clearPipe();
    repeat (16) @(posedge clk);
    #1;
    rstN = 1'b1;
    waitOutputsClear(cleared);
    if (cleared) begin
      resetMidStream();
      scanPartEdges();
      overlapPriority();
      switchAnchor();
      toggleEnable();
      randomPixels();
    end
    $display("Error counts: pixValid %0d, pixColour %0d, other %0d",
             validErrors, colourErrors, otherErrors);
    if (validErrors + colourErrors + otherErrors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: drawFigure.f
common/figurePkg.sv
spriteBlock/spriteShape.sv
spriteBlock/spriteBlock.sv
design/figureCompositor.sv
design/drawFigure.sv
testbench/drawFigureTb_sva.sv
testbench/drawFigureTb.sv

// File: runSim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module drawFigureTb -f drawFigure.f -o drawFigureSim &&
  ./obj_dir/drawFigureSim | tee /dev/stderr | grep -x "Testbench passed" > /dev/null &&
  echo "simulation run passed" ||
  { echo "simulation run failed"; exit 1; }
